/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mps_top
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_MSG ?= TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* mps_axi_lite_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mps_macros.svh"

module mps_axi_lite_slave
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [`MPS_ADDR_W-1:0] i_awaddr,
	input logic i_awvalid,
	output logic o_awready,
	input logic [`MPS_DATA_W-1:0] i_wdata,
	input logic [`MPS_DATA_W/8-1:0] i_wstrb,
	input logic i_wvalid,
	output logic o_wready,
	output logic [1:0] o_bresp,
	output logic o_bvalid,
	input logic i_bready,
	input logic [`MPS_ADDR_W-1:0] i_araddr,
	input logic i_arvalid,
	output logic o_arready,
	output logic [1:0] o_rresp,
	output logic o_rvalid,
	output logic [`MPS_DATA_W-1:0] o_rdata,
	input logic i_rready,
	input logic [`MPS_DATA_W-1:0] i_rdata,
	output mps_axi_pkg::axi_wr_t o_wr,
	output mps_axi_pkg::axi_rd_t o_rd
);
	import mps_axi_pkg::*;

	localparam int ADDR_LSB = 2;

	logic aw_en;
	logic [WORD_W-1:0] aw_word;
	logic [WORD_W-1:0] ar_word;
	logic wr_fire;
	logic rd_fire;
	logic aw_accept;

	assign aw_accept = !o_awready && i_awvalid && i_wvalid && aw_en;
	assign wr_fire = o_awready && i_awvalid && o_wready && i_wvalid;
	assign rd_fire = o_arready && i_arvalid && !o_rvalid;

	// aw_en holds off a new write until the B handshake
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			aw_en <= 1'b1;
		end
		else if (aw_accept)
		begin
			o_awready <= 1'b1;
			o_wready <= 1'b1;
			aw_en <= 1'b0;
		end
		else
		begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			if (i_bready && o_bvalid)
				aw_en <= 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_accept)
			aw_word <= i_awaddr[ADDR_LSB +: WORD_W];
		if (!o_arready && i_arvalid && !o_rvalid)
			ar_word <= i_araddr[ADDR_LSB +: WORD_W];
	end

	// Write response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (wr_fire)
			o_bvalid <= 1'b1;
		else if (i_bready && o_bvalid)
			o_bvalid <= 1'b0;
	end

	// Read address and read valid
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			o_arready <= !o_arready && i_arvalid && !o_rvalid;
			if (rd_fire)
				o_rvalid <= 1'b1;
			else if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
		end
	end

	assign o_wr = '{en: wr_fire, word: aw_word, data: i_wdata, strb: i_wstrb};
	assign o_rd = '{en: rd_fire, word: ar_word};
	assign o_rdata = i_rdata;
	assign o_bresp = 2'b00;
	assign o_rresp = 2'b00;

	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

	a_no_wr_during_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_bvalid |-> !o_wr.en);

endmodule

`default_nettype wire

/* mps_axi_pkg.sv */
`default_nettype none

`include "mps_macros.svh"

package mps_axi_pkg;

	localparam int WORD_W = $clog2(`MPS_WORDS);
	localparam int STRB_W = `MPS_DATA_W / 8;

	// One accepted AXI write, valid for a single cycle
	typedef struct packed
	{
		logic en;
		logic [WORD_W-1:0] word;
		logic [`MPS_DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axi_wr_t;

	// One accepted AXI read
	typedef struct packed
	{
		logic en;
		logic [WORD_W-1:0] word;
	} axi_rd_t;

endpackage

`default_nettype wire

/* mps_loop_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mps_macros.svh"

module mps_loop_regs
#(
	parameter int BASE = `MPS_W_LOOP0
)
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input mps_axi_pkg::axi_wr_t i_wr,
	output mps_reg_pkg::loop_params_t o_raw,
	output mps_reg_pkg::loop_params_t o_params
);
	import mps_axi_pkg::*;
	import mps_reg_pkg::*;

	logic [`MPS_LOOP_WORDS-1:0][`MPS_DATA_W-1:0] regs;

	// Byte-strobed writes to words BASE..BASE+5
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			regs <= '0;
		else if (i_wr.en)
		begin
			for (int k = 0; k < `MPS_LOOP_WORDS; k++)
			begin
				if (i_wr.word == WORD_W'(BASE + k))
				begin
					for (int b = 0; b < STRB_W; b++)
					begin
						if (i_wr.strb[b])
							regs[k][8*b +: 8] <= i_wr.data[8*b +: 8];
					end
				end
			end
		end
	end

	assign o_raw = '{set: regs[0], min: regs[1], max: regs[2],
		p: regs[3], i: regs[4], d: regs[5]};

	// Unsigned clamp, min wins when limits cross
	always_comb
	begin
		o_params = o_raw;
		if (o_raw.min > o_raw.max)
			o_params.set = o_raw.min;
		else if (o_raw.set < o_raw.min)
			o_params.set = o_raw.min;
		else if (o_raw.set > o_raw.max)
			o_params.set = o_raw.max;
	end

	a_set_in_limits: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_raw.min <= o_raw.max |-> o_params.set >= o_raw.min && o_params.set <= o_raw.max);

endmodule

`default_nettype wire

/* mps_macros.svh */
`ifndef MPS_MACROS_SVH
`define MPS_MACROS_SVH

// AXI side
`define MPS_DATA_W 32
`define MPS_ADDR_W 8
`define MPS_WORDS 64

// DSP external bus
`define MPS_XADDR_W 9

// Word map
`define MPS_W_CTRL 0
// Current loop words 1..6 as set, min, max, p, i, d
`define MPS_W_LOOP0 1
// Voltage loop words 7..12
`define MPS_W_LOOP1 7
// ADC words c, v, dc_c, dc_v
`define MPS_W_ADC 16
`define MPS_W_MBOX 20

// Loop banks
`define MPS_LOOPS 2
`define MPS_LOOP_WORDS 6

`endif

/* mps_readback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mps_macros.svh"

module mps_readback
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input mps_axi_pkg::axi_wr_t i_wr,
	input mps_axi_pkg::axi_rd_t i_rd,
	input mps_reg_pkg::loop_params_t [`MPS_LOOPS-1:0] i_loops,
	input mps_reg_pkg::adc_sample_t i_adc,
	input logic [`MPS_XADDR_W-1:0] i_xintf_addr,
	input logic [`MPS_DATA_W/2-1:0] i_xintf_wdata,
	input logic i_xintf_we_n,
	output logic [`MPS_DATA_W-1:0] o_rdata,
	output logic [`MPS_DATA_W/2-1:0] o_xintf_rdata,
	output logic [3:0] o_ctrl,
	output mps_reg_pkg::mbox_t o_mbox
);
	import mps_axi_pkg::*;
	import mps_reg_pkg::*;

	localparam logic [`MPS_XADDR_W-1:0] XMBOX = 64;
	// DSP readable range, words 0..19
	localparam logic [`MPS_XADDR_W-1:0] XRD_END = 40;

	logic [`MPS_DATA_W-1:0] ctrl_q;
	adc_sample_t adc_q;
	logic [1:0][`MPS_DATA_W-1:0] mbox_q;
	logic [`MPS_DATA_W-1:0] map [`MPS_WORDS];
	logic [`MPS_DATA_W-1:0] xsel;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ctrl_q <= '0;
			adc_q <= '0;
			mbox_q <= '0;
			o_rdata <= '0;
		end
		else
		begin
			if (i_wr.en && i_wr.word == WORD_W'(`MPS_W_CTRL))
			begin
				for (int b = 0; b < STRB_W; b++)
				begin
					if (i_wr.strb[b])
						ctrl_q[8*b +: 8] <= i_wr.data[8*b +: 8];
				end
			end
			adc_q <= i_adc;
			// Mailbox halves at 64 + 2k + h
			if (!i_xintf_we_n && i_xintf_addr[`MPS_XADDR_W-1:2] == XMBOX[`MPS_XADDR_W-1:2])
			begin
				if (i_xintf_addr[0])
					mbox_q[i_xintf_addr[1]][31:16] <= i_xintf_wdata;
				else
					mbox_q[i_xintf_addr[1]][15:0] <= i_xintf_wdata;
			end
			if (i_rd.en)
				o_rdata <= map[i_rd.word];
		end
	end

	// Word map shared by both read paths, holes read 0
	always_comb
	begin
		for (int k = 0; k < `MPS_WORDS; k++)
			map[k] = '0;
		map[`MPS_W_CTRL] = ctrl_q;
		for (int l = 0; l < `MPS_LOOPS; l++)
		begin
			map[`MPS_W_LOOP0 + l*`MPS_LOOP_WORDS + 0] = i_loops[l].set;
			map[`MPS_W_LOOP0 + l*`MPS_LOOP_WORDS + 1] = i_loops[l].min;
			map[`MPS_W_LOOP0 + l*`MPS_LOOP_WORDS + 2] = i_loops[l].max;
			map[`MPS_W_LOOP0 + l*`MPS_LOOP_WORDS + 3] = i_loops[l].p;
			map[`MPS_W_LOOP0 + l*`MPS_LOOP_WORDS + 4] = i_loops[l].i;
			map[`MPS_W_LOOP0 + l*`MPS_LOOP_WORDS + 5] = i_loops[l].d;
		end
		map[`MPS_W_ADC + 0] = adc_q.c;
		map[`MPS_W_ADC + 1] = adc_q.v;
		map[`MPS_W_ADC + 2] = adc_q.dc_c;
		map[`MPS_W_ADC + 3] = adc_q.dc_v;
		map[`MPS_W_MBOX + 0] = mbox_q[0];
		map[`MPS_W_MBOX + 1] = mbox_q[1];
	end

	assign xsel = map[i_xintf_addr[WORD_W:1]];
	assign o_xintf_rdata = (i_xintf_addr >= XRD_END) ? '0 :
		i_xintf_addr[0] ? xsel[31:16] : xsel[15:0];

	assign o_ctrl = ctrl_q[3:0];
	assign o_mbox = '{w1: mbox_q[1], w0: mbox_q[0]};

	a_xintf_wr_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!i_xintf_we_n |-> i_xintf_addr < XMBOX + 8);

endmodule

`default_nettype wire

/* mps_reg_pkg.sv */
`default_nettype none

`include "mps_macros.svh"

package mps_reg_pkg;

	// One regulation loop, MSB field first
	typedef struct packed
	{
		logic [`MPS_DATA_W-1:0] set;
		logic [`MPS_DATA_W-1:0] min;
		logic [`MPS_DATA_W-1:0] max;
		logic [`MPS_DATA_W-1:0] p;
		logic [`MPS_DATA_W-1:0] i;
		logic [`MPS_DATA_W-1:0] d;
	} loop_params_t;

	typedef struct packed
	{
		logic [`MPS_DATA_W-1:0] c;
		logic [`MPS_DATA_W-1:0] v;
		logic [`MPS_DATA_W-1:0] dc_c;
		logic [`MPS_DATA_W-1:0] dc_v;
	} adc_sample_t;

	typedef struct packed
	{
		logic [`MPS_DATA_W-1:0] w1;
		logic [`MPS_DATA_W-1:0] w0;
	} mbox_t;

	typedef enum logic [0:0]
	{
		LOOP_CURRENT = 1'b0,
		LOOP_VOLTAGE = 1'b1
	} loop_idx_e;

endpackage

`default_nettype wire

/* mps_reg_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mps_macros.svh"

module mps_reg_top
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [`MPS_ADDR_W-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input logic [`MPS_DATA_W-1:0] S_AXI_WDATA,
	input logic [`MPS_DATA_W/8-1:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [`MPS_ADDR_W-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [`MPS_DATA_W-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input mps_reg_pkg::adc_sample_t i_adc,
	input logic [`MPS_XADDR_W-1:0] i_xintf_addr,
	input logic [`MPS_DATA_W/2-1:0] i_xintf_wdata,
	input logic i_xintf_we_n,
	output logic [`MPS_DATA_W/2-1:0] o_xintf_rdata,
	output logic [3:0] o_ctrl,
	output mps_reg_pkg::loop_params_t [`MPS_LOOPS-1:0] o_loop_params,
	output mps_reg_pkg::mbox_t o_mbox
);
	import mps_axi_pkg::*;
	import mps_reg_pkg::*;

	axi_wr_t wr;
	axi_rd_t rd;
	loop_params_t [`MPS_LOOPS-1:0] loop_raw;
	logic [`MPS_DATA_W-1:0] rdata;

	mps_axi_lite_slave u_slave (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awaddr(S_AXI_AWADDR), .i_awvalid(S_AXI_AWVALID), .o_awready(S_AXI_AWREADY),
		.i_wdata(S_AXI_WDATA), .i_wstrb(S_AXI_WSTRB), .i_wvalid(S_AXI_WVALID),
		.o_wready(S_AXI_WREADY), .o_bresp(S_AXI_BRESP), .o_bvalid(S_AXI_BVALID),
		.i_bready(S_AXI_BREADY), .i_araddr(S_AXI_ARADDR), .i_arvalid(S_AXI_ARVALID),
		.o_arready(S_AXI_ARREADY), .o_rresp(S_AXI_RRESP), .o_rvalid(S_AXI_RVALID),
		.o_rdata(S_AXI_RDATA), .i_rready(S_AXI_RREADY), .i_rdata(rdata),
		.o_wr(wr), .o_rd(rd)
	);

	// Current bank first, voltage bank next
	for (genvar g = 0; g < `MPS_LOOPS; g++)
	begin : g_loop
		localparam loop_idx_e IDX = loop_idx_e'(g);

		mps_loop_regs #(.BASE(`MPS_W_LOOP0 + `MPS_LOOP_WORDS * int'(IDX))) u_loop (
			.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
			.i_wr(wr), .o_raw(loop_raw[g]), .o_params(o_loop_params[g])
		);
	end

	mps_readback u_readback (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr(wr), .i_rd(rd), .i_loops(loop_raw), .i_adc(i_adc),
		.i_xintf_addr(i_xintf_addr), .i_xintf_wdata(i_xintf_wdata),
		.i_xintf_we_n(i_xintf_we_n), .o_rdata(rdata), .o_xintf_rdata(o_xintf_rdata),
		.o_ctrl(o_ctrl), .o_mbox(o_mbox)
	);

endmodule

`default_nettype wire

/* tb_mps_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mps_macros.svh"

module tb_mps_checker
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic i_bvalid,
	input logic i_bready,
	input logic [1:0] i_bresp,
	input logic i_rvalid,
	input logic i_rready,
	input logic [1:0] i_rresp,
	input logic [`MPS_DATA_W-1:0] i_rdata,
	input logic [`MPS_DATA_W-1:0] i_exp_rdata,
	input logic [3:0] i_ctrl,
	input logic [3:0] i_exp_ctrl,
	input mps_reg_pkg::loop_params_t [`MPS_LOOPS-1:0] i_loops,
	input mps_reg_pkg::loop_params_t [`MPS_LOOPS-1:0] i_exp_loops,
	input mps_reg_pkg::mbox_t i_mbox,
	input mps_reg_pkg::mbox_t i_exp_mbox,
	input logic [`MPS_DATA_W/2-1:0] i_xrdata,
	input logic [`MPS_DATA_W/2-1:0] i_exp_xrdata,
	input logic i_xcheck,
	output int o_errors,
	output int o_reads
);

	int errors = 0;
	int reads = 0;
	logic b_wait;
	logic r_wait;
	logic [`MPS_DATA_W-1:0] r_held;

	task automatic compare(input string name, input logic [191:0] got, input logic [191:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// Sampled mid-cycle, away from the stimulus edge
	always @(negedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			b_wait = 1'b0;
			r_wait = 1'b0;
		end
		else
		begin
			compare("o_ctrl", 192'(i_ctrl), 192'(i_exp_ctrl));
			for (int l = 0; l < `MPS_LOOPS; l++)
				compare($sformatf("o_loop_params[%0d]", l), 192'(i_loops[l]), 192'(i_exp_loops[l]));
			compare("o_mbox", 192'(i_mbox), 192'(i_exp_mbox));
			if (b_wait && !i_bvalid)
			begin
				errors++;
				$display("BVALID dropped while BREADY was still low");
			end
			if (r_wait)
			begin
				if (!i_rvalid)
				begin
					errors++;
					$display("RVALID dropped while RREADY was still low");
				end
				compare("S_AXI_RDATA (held)", 192'(i_rdata), 192'(r_held));
			end
			if (i_bvalid)
				compare("S_AXI_BRESP", 192'(i_bresp), 192'(0));
			if (i_rvalid && i_rready)
			begin
				reads++;
				compare("S_AXI_RDATA", 192'(i_rdata), 192'(i_exp_rdata));
				compare("S_AXI_RRESP", 192'(i_rresp), 192'(0));
			end
			if (i_xcheck)
				compare("o_xintf_rdata", 192'(i_xrdata), 192'(i_exp_xrdata));
			b_wait = i_bvalid && !i_bready;
			r_wait = i_rvalid && !i_rready;
			r_held = i_rdata;
		end
	end

	assign o_errors = errors;
	assign o_reads = reads;

endmodule

`default_nettype wire

/* tb_mps_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mps_clkgen
#(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 2
)
(
	output logic S_AXI_ACLK,
	output logic S_AXI_ARESETN
);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#(PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Release just after an edge, like the rest of the stimulus
	initial
	begin
		S_AXI_ARESETN = 1'b0;
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
	end

endmodule

`default_nettype wire

/* tb_mps_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mps_macros.svh"

module tb_mps_top;
	import mps_reg_pkg::*;

	localparam int N_SHADOW = `MPS_W_MBOX + 2;
	localparam int LAST_RW = `MPS_W_LOOP1 + `MPS_LOOP_WORDS - 1;
	localparam int N_XREAD = 2 * `MPS_W_MBOX;
	localparam int N_RAND = 16;
	localparam int N_BP = 4;
	localparam int N_ADC = 2;
	localparam int MAX_HOLD = 6;
	// AXI and DSP transaction counts over all tests
	localparam int AXI_TX = N_SHADOW + 2 * N_RAND + 3 + 12 * `MPS_LOOPS + 4 * N_ADC + 2 + 3 * N_BP;
	localparam int DSP_TX = 2 * N_XREAD + 6;
	localparam int CYCLE_LIMIT = AXI_TX * (8 + MAX_HOLD) + DSP_TX * 3 + 20;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [`MPS_ADDR_W-1:0] awaddr;
	logic [`MPS_ADDR_W-1:0] araddr;
	logic [`MPS_DATA_W-1:0] wdata;
	logic [`MPS_DATA_W-1:0] rdata;
	logic [3:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	adc_sample_t adc;
	logic [`MPS_XADDR_W-1:0] xaddr;
	logic [15:0] xwdata, xrdata, exp_xrdata;
	logic xwe_n, xcheck;
	logic [3:0] ctrl, exp_ctrl;
	loop_params_t [`MPS_LOOPS-1:0] loops, exp_loops;
	mbox_t mbox, exp_mbox;
	logic [`MPS_DATA_W-1:0] shadow [N_SHADOW];
	logic [`MPS_DATA_W-1:0] exp_rdata;
	int pend_word;
	logic [`MPS_DATA_W-1:0] pend_data;
	logic [3:0] pend_strb;
	integer seed;
	int errors, chk_errors, reads_issued, reads_seen;
	int cycles = 0;

	tb_mps_clkgen u_clkgen (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN));

	mps_reg_top dut0 (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid),
		.S_AXI_WREADY(wready), .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid),
		.S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready), .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready), .i_adc(adc),
		.i_xintf_addr(xaddr), .i_xintf_wdata(xwdata), .i_xintf_we_n(xwe_n),
		.o_xintf_rdata(xrdata), .o_ctrl(ctrl), .o_loop_params(loops), .o_mbox(mbox)
	);

	tb_mps_checker u_checker (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_bvalid(bvalid), .i_bready(bready), .i_bresp(bresp),
		.i_rvalid(rvalid), .i_rready(rready), .i_rresp(rresp),
		.i_rdata(rdata), .i_exp_rdata(exp_rdata), .i_ctrl(ctrl), .i_exp_ctrl(exp_ctrl),
		.i_loops(loops), .i_exp_loops(exp_loops), .i_mbox(mbox), .i_exp_mbox(exp_mbox),
		.i_xrdata(xrdata), .i_exp_xrdata(exp_xrdata), .i_xcheck(xcheck),
		.o_errors(chk_errors), .o_reads(reads_seen)
	);

	// Expected word from the shadow map with optional setpoint clamp
	function automatic logic [31:0] mps_ref(input int word, input bit clamped);
		logic [31:0] v;
		logic [31:0] lo;
		logic [31:0] hi;
		int base;
		v = (word < N_SHADOW) ? shadow[word] : '0;
		for (int l = 0; l < `MPS_LOOPS; l++)
		begin
			base = `MPS_W_LOOP0 + `MPS_LOOP_WORDS * l;
			if (clamped && word == base)
			begin
				lo = shadow[base + 1];
				hi = shadow[base + 2];
				if (lo > hi)
					v = lo;
				else if (v < lo)
					v = lo;
				else if (v > hi)
					v = hi;
			end
		end
		return v;
	endfunction

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	task automatic refresh_expect();
		int base;
		exp_ctrl = shadow[`MPS_W_CTRL][3:0];
		for (int l = 0; l < `MPS_LOOPS; l++)
		begin
			base = `MPS_W_LOOP0 + `MPS_LOOP_WORDS * l;
			exp_loops[l] = '{set: mps_ref(base, 1'b1), min: shadow[base + 1],
				max: shadow[base + 2], p: shadow[base + 3], i: shadow[base + 4],
				d: shadow[base + 5]};
		end
		exp_mbox = '{w1: shadow[`MPS_W_MBOX + 1], w0: shadow[`MPS_W_MBOX]};
	endtask

	task automatic after_edge();
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic put_write(input int word, input logic [31:0] data, input logic [3:0] strb);
		after_edge();
		awaddr = 8'(word * 4);
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		pend_word = word;
		pend_data = data;
		pend_strb = strb;
	endtask

	// Shadow takes the pending write once the handshake is done
	task automatic accept_write();
		do @(negedge S_AXI_ACLK); while (!awready);
		if (wready !== 1'b1)
		begin
			errors++;
			$display("FAIL S_AXI_WREADY got 0x%0h expected 0x1", wready);
		end
		after_edge();
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (pend_word <= LAST_RW)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (pend_strb[b])
					shadow[pend_word][8*b +: 8] = pend_data[8*b +: 8];
			end
		end
		refresh_expect();
	endtask

	task automatic respond(input int hold);
		do @(negedge S_AXI_ACLK); while (!bvalid);
		repeat (hold) @(negedge S_AXI_ACLK);
		after_edge();
		bready = 1'b1;
		after_edge();
		bready = 1'b0;
	endtask

	task automatic write_word(input int word, input logic [31:0] data, input logic [3:0] strb);
		put_write(word, data, strb);
		accept_write();
		respond(0);
	endtask

	// Second write waits behind a stalled response
	task automatic blocked_write(input int w1, input int w2, input int hold);
		put_write(w1, $random(seed), 4'hf);
		accept_write();
		do @(negedge S_AXI_ACLK); while (!bvalid);
		put_write(w2, $random(seed), 4'($random(seed)));
		repeat (hold)
		begin
			@(negedge S_AXI_ACLK);
			if (awready)
			begin
				errors++;
				$display("Second write accepted while the first response was pending");
			end
		end
		respond(0);
		accept_write();
		respond(0);
	endtask

	task automatic read_word(input int word, input int hold);
		exp_rdata = mps_ref(word, 1'b0);
		after_edge();
		araddr = 8'(word * 4);
		arvalid = 1'b1;
		reads_issued++;
		do @(negedge S_AXI_ACLK); while (!arready);
		after_edge();
		arvalid = 1'b0;
		do @(negedge S_AXI_ACLK); while (!rvalid);
		repeat (hold) @(negedge S_AXI_ACLK);
		after_edge();
		rready = 1'b1;
		after_edge();
		rready = 1'b0;
	endtask

	task automatic dsp_read(input int addr);
		logic [31:0] w;
		w = mps_ref(addr / 2, 1'b0);
		after_edge();
		xaddr = 9'(addr);
		if (addr >= N_XREAD)
			exp_xrdata = '0;
		else
			exp_xrdata = (addr % 2 == 1) ? w[31:16] : w[15:0];
		xcheck = 1'b1;
		after_edge();
		xcheck = 1'b0;
	endtask

	// Mailbox half at 64 + 2k + h
	task automatic dsp_write(input int addr, input logic [15:0] data);
		int k;
		k = `MPS_W_MBOX + (addr / 2) % 2;
		after_edge();
		xaddr = 9'(addr);
		xwdata = data;
		xwe_n = 1'b0;
		after_edge();
		xwe_n = 1'b1;
		if (addr % 2 == 1)
			shadow[k][31:16] = data;
		else
			shadow[k][15:0] = data;
		refresh_expect();
	endtask

	task automatic drive_adc();
		after_edge();
		adc = '{c: $random(seed), v: $random(seed), dc_c: $random(seed), dc_v: $random(seed)};
		shadow[`MPS_W_ADC + 0] = adc.c;
		shadow[`MPS_W_ADC + 1] = adc.v;
		shadow[`MPS_W_ADC + 2] = adc.dc_c;
		shadow[`MPS_W_ADC + 3] = adc.dc_v;
	endtask

	task automatic clamp_case(input loop_idx_e li, input logic [31:0] set,
		input logic [31:0] lo, input logic [31:0] hi);
		int base;
		base = `MPS_W_LOOP0 + `MPS_LOOP_WORDS * int'(li);
		write_word(base + 1, lo, 4'hf);
		write_word(base + 2, hi, 4'hf);
		write_word(base, set, 4'hf);
	endtask

	always @(posedge S_AXI_ACLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with the tests still running", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		int w;
		logic [31:0] lo;
		logic [31:0] hi;
		loop_idx_e li;
		seed = 90461;
		errors = 0;
		reads_issued = 0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		adc = '0;
		xaddr = '0;
		xwdata = '0;
		xwe_n = 1'b1;
		xcheck = 1'b0;
		exp_rdata = '0;
		exp_xrdata = '0;
		for (int k = 0; k < N_SHADOW; k++)
			shadow[k] = '0;
		refresh_expect();

		wait (S_AXI_ARESETN === 1'b1);
		@(negedge S_AXI_ACLK);
		if ({awready, wready, bvalid, arready, rvalid} !== 5'b0)
		begin
			errors++;
			$display("FAIL AXI ready/valid after reset got 0x%0h expected 0x0",
				{awready, wready, bvalid, arready, rvalid});
		end
		for (int k = 0; k < N_SHADOW; k++)
			read_word(k, 0);
		for (int a = 0; a < N_XREAD; a++)
			dsp_read(a);

		for (int n = 0; n < N_RAND; n++)
		begin
			w = rand_below(LAST_RW + 1);
			write_word(w, $random(seed), 4'($random(seed)));
			read_word(w, 0);
		end
		// Holes in the map
		write_word(14, $random(seed), 4'hf);
		read_word(14, 0);
		read_word(40, 0);

		// Below, inside, above, then crossed limits
		for (int l = 0; l < `MPS_LOOPS; l++)
		begin
			li = loop_idx_e'(l);
			lo = 32'h1000 + 32'(rand_below(65536));
			hi = lo + 32'h1000 + 32'(rand_below(65536));
			clamp_case(li, lo - 1 - 32'(rand_below(4096)), lo, hi);
			clamp_case(li, lo + (hi - lo) / 2, lo, hi);
			clamp_case(li, hi + 1 + 32'(rand_below(65536)), lo, hi);
			clamp_case(li, lo + (hi - lo) / 2, hi, lo);
		end

		for (int n = 0; n < N_ADC; n++)
		begin
			drive_adc();
			for (int k = 0; k < 4; k++)
				read_word(`MPS_W_ADC + k, 0);
		end

		for (int a = 0; a < N_XREAD; a++)
			dsp_read(a);
		dsp_read(N_XREAD);
		dsp_read(64);
		for (int a = 64; a < 68; a++)
			dsp_write(a, 16'($random(seed)));
		read_word(`MPS_W_MBOX, 0);
		read_word(`MPS_W_MBOX + 1, 0);

		for (int n = 0; n < N_BP; n++)
		begin
			blocked_write(rand_below(LAST_RW + 1), rand_below(LAST_RW + 1),
				1 + rand_below(MAX_HOLD));
			read_word(rand_below(N_SHADOW), 1 + rand_below(MAX_HOLD));
		end

		repeat (2) @(negedge S_AXI_ACLK);
		if (reads_seen != reads_issued)
		begin
			errors++;
			$display("Only %0d of %0d read responses were seen", reads_seen, reads_issued);
		end
		$display("Errors: %0d in testbench, %0d in checker", errors, chk_errors);
		if (errors + chk_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
mps_axi_pkg.sv
mps_reg_pkg.sv
mps_axi_lite_slave.sv
mps_loop_regs.sv
mps_readback.sv
mps_reg_top.sv
tb_mps_clkgen.sv
tb_mps_checker.sv
tb_mps_top.sv
